// File: rapcore_pkg.sv
`default_nettype none

package rapcore_pkg;

  // Host words are 64 bits, command header in the top byte
  parameter int WORD_BITS = 64;

  // Header codes
  // Coordinated move, three data words follow
  parameter logic [7:0] CMD_COORDINATED_STEP = 8'h01;
  // Single word, enable level in bit 0
  parameter logic [7:0] CMD_MOTOR_ENABLE = 8'h0a;
  // Single word, divisor in the low byte
  parameter logic [7:0] CMD_CLK_DIVISOR = 8'h03;
  // Version reply goes out on the next transfer
  parameter logic [7:0] CMD_API_VERSION = 8'hfe;

  // API version fields
  // Reply byte 2
  parameter logic [7:0] VERSION_MAJOR = 8'd0;
  // Reply byte 1
  parameter logic [7:0] VERSION_MINOR = 8'd1;
  // Reply byte 0
  parameter logic [7:0] VERSION_PATCH = 8'd0;

  // DDA tick every 40 clocks out of reset
  parameter logic [7:0] DEFAULT_CLOCK_DIVISOR = 8'd40;

endpackage

`default_nettype wire

// File: spi_word.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word
  import rapcore_pkg::*;
(
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire                   sck,
  input  wire                   cs,
  input  wire                   copi,
  output wire                   cipo,
  input  wire  [WORD_BITS-1:0]  word_send_data,
  output logic                  word_received,
  output logic [WORD_BITS-1:0]  word_data_received
);

  localparam int CNT_BITS = $clog2(WORD_BITS);
  localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(WORD_BITS - 1);

  // Two sync flops, third flop keeps the previous level
  logic [2:0]           sck_r;
  logic [2:0]           cs_r;
  // Data only needs the two sync flops
  logic [1:0]           copi_r;
  logic [CNT_BITS-1:0]  bit_cnt;
  logic [WORD_BITS-1:0] rx_shift;
  logic [WORD_BITS-1:0] tx_shift;

  // Edges seen on the synchronized pins
  wire sck_rise = (sck_r[2:1] == 2'b01);
  wire sck_fall = (sck_r[2:1] == 2'b10);
  wire cs_fall  = (cs_r[2:1] == 2'b10);
  // CS is active low
  wire selected = ~cs_r[1];

  // MSB of the send register drives the pin
  assign cipo = tx_shift[WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r         <= '0;
      // Idle high so reset does not look like a select
      cs_r          <= '1;
      bit_cnt       <= '0;
      tx_shift      <= '0;
      word_received <= 1'b0;
    end else begin
      sck_r         <= {sck_r[1:0], sck};
      cs_r          <= {cs_r[1:0], cs};
      word_received <= 1'b0;
      if (cs_fall) begin
        // New transfer, latch the prepared reply
        bit_cnt  <= '0;
        tx_shift <= word_send_data;
      end else if (selected) begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 1'b1;
          // Counter wraps by itself after the last bit
          if (bit_cnt == LAST_BIT) begin
            word_received <= 1'b1;
          end
        end
        // Mode 0, next bit out on the falling edge
        if (sck_fall) begin
          tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // Receive path, MSB first
  always_ff @(posedge CLK) begin
    copi_r <= {copi_r[0], copi};
    if (selected && sck_rise) begin
      rx_shift <= {rx_shift[WORD_BITS-2:0], copi_r[1]};
      // Full word handed over with the strobe
      if (bit_cnt == LAST_BIT) begin
        word_data_received <= {rx_shift[WORD_BITS-2:0], copi_r[1]};
      end
    end
  end

endmodule

`default_nettype wire

// File: command_handler.sv
`timescale 1ns/1ps
`default_nettype none

module command_handler
  import rapcore_pkg::*;
#(
  parameter int MOVE_BUFFER_BITS = 1,
  parameter int ENC_BITS         = 64
) (
  input  wire                               CLK,
  input  wire                               resetn,
  input  wire                               word_received,
  input  wire  [WORD_BITS-1:0]              word_data_received,
  output wire  [WORD_BITS-1:0]              word_send_data,
  input  wire  signed [ENC_BITS-1:0]        enc_count,
  input  wire  [MOVE_BUFFER_BITS-1:0]       moveind,
  input  wire  [(1<<MOVE_BUFFER_BITS)-1:0]  stepfinished,
  output logic [(1<<MOVE_BUFFER_BITS)-1:0]  stepready,
  output wire  [WORD_BITS-1:0]              move_duration,
  output wire  [WORD_BITS-1:0]              increment,
  output wire  [WORD_BITS-1:0]              incrementincrement,
  output wire                               move_dir,
  output logic [7:0]                        clock_divisor,
  output logic                              enable,
  output wire                               buffer_dtr
);

  localparam int DEPTH = 1 << MOVE_BUFFER_BITS;

  // Move slots, read by the DDA at moveind
  logic [WORD_BITS-1:0] dur_mem    [DEPTH];
  logic [WORD_BITS-1:0] inc_mem    [DEPTH];
  logic [WORD_BITS-1:0] incinc_mem [DEPTH];
  logic                 dir_mem    [DEPTH];

  // Fields held until the last word lands
  logic                        dir_stage;
  logic [WORD_BITS-1:0]        dur_stage;
  logic [WORD_BITS-1:0]        inc_stage;
  // Encoder count taken at the move header
  logic signed [WORD_BITS-1:0] enc_store;

  logic [7:0]                  message_header;
  // Words seen in the current message, header is 1
  logic [1:0]                  word_count;
  logic [MOVE_BUFFER_BITS-1:0] write_ind;
  logic [WORD_BITS-1:0]        reply;

  wire [7:0] header_in = word_data_received[WORD_BITS-1 -: 8];
  // Multi-word messages still collecting data
  wire awaiting = (message_header == CMD_COORDINATED_STEP) ||
                  (message_header == CMD_API_VERSION);
  wire move_word = word_received && (message_header == CMD_COORDINATED_STEP);
  wire commit    = move_word && (word_count == 2'd3);
  // Toggle bits equal means the DDA is done with the slot
  wire slot_free = (stepready[write_ind] == stepfinished[write_ind]);

  assign word_send_data     = reply;
  assign buffer_dtr         = slot_free;
  assign move_duration      = dur_mem[moveind];
  assign increment          = inc_mem[moveind];
  assign incrementincrement = incinc_mem[moveind];
  assign move_dir           = dir_mem[moveind];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      message_header <= '0;
      word_count     <= '0;
      enable         <= 1'b0;
      clock_divisor  <= DEFAULT_CLOCK_DIVISOR;
      stepready      <= '0;
      write_ind      <= '0;
      reply          <= '0;
    end else if (word_received) begin
      // Reply only lives for one transfer
      reply <= '0;
      if (!awaiting) begin
        message_header <= header_in;
        word_count     <= 2'd1;
        case (header_in)
          CMD_MOTOR_ENABLE: enable <= word_data_received[0];
          CMD_CLK_DIVISOR:  clock_divisor <= word_data_received[7:0];
          // Patch, minor, major from the low byte up
          CMD_API_VERSION:  reply <= WORD_BITS'({VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});
          default: ;
        endcase
      end else if (message_header == CMD_API_VERSION) begin
        // Follow-up word carries nothing
        message_header <= '0;
        word_count     <= '0;
      end else begin
        word_count <= word_count + 1'b1;
        // Encoder snapshot rides out on the third data word
        if (word_count == 2'd2) begin
          reply <= enc_store;
        end
        if (word_count == 2'd3) begin
          message_header <= '0;
          word_count     <= '0;
          // Full buffer drops the move
          if (slot_free) begin
            stepready[write_ind] <= ~stepready[write_ind];
            write_ind            <= write_ind + 1'b1;
          end
        end
      end
    end
  end

  // Move staging and slot writes
  always_ff @(posedge CLK) begin
    if (word_received && !awaiting && (header_in == CMD_COORDINATED_STEP)) begin
      dir_stage <= word_data_received[0];
      // Sign extends to the word
      enc_store <= enc_count;
    end
    if (move_word && (word_count == 2'd1)) begin
      dur_stage <= word_data_received;
    end
    if (move_word && (word_count == 2'd2)) begin
      inc_stage <= word_data_received;
    end
    if (commit && slot_free) begin
      dir_mem[write_ind]    <= dir_stage;
      dur_mem[write_ind]    <= dur_stage;
      inc_mem[write_ind]    <= inc_stage;
      incinc_mem[write_ind] <= word_data_received;
    end
  end

  // Host overran the buffer, the DDA still owns this slot
  a_commit_free: assert property (@(posedge CLK) disable iff (!resetn)
    commit |-> slot_free)
    else $error("move dropped, slot %0d still pending", write_ind);

endmodule

`default_nettype wire

// File: dda_timer.sv
`timescale 1ns/1ps
`default_nettype none

module dda_timer
  import rapcore_pkg::*;
#(
  parameter int MOVE_BUFFER_BITS = 1
) (
  input  wire                               CLK,
  input  wire                               resetn,
  input  wire  [7:0]                        clock_divisor,
  input  wire  [WORD_BITS-1:0]              move_duration,
  input  wire  [WORD_BITS-1:0]              increment,
  input  wire  [WORD_BITS-1:0]              incrementincrement,
  input  wire                               move_dir,
  input  wire  [(1<<MOVE_BUFFER_BITS)-1:0]  stepready,
  output logic [(1<<MOVE_BUFFER_BITS)-1:0]  stepfinished,
  output logic [MOVE_BUFFER_BITS-1:0]       moveind,
  output logic                              step,
  output logic                              dir,
  output logic                              move_done
);

  logic [7:0]           div_cnt;
  logic                 active;
  // Phase accumulator, carry out is a step
  logic [WORD_BITS-1:0] accum;
  // Velocity, bent by incrementincrement each tick
  logic [WORD_BITS-1:0] work_inc;
  logic [WORD_BITS-1:0] tick_cnt;

  // Divisor of 0 or 1 ticks every clock
  wire tick = ({1'b0, div_cnt} + 9'd1) >= {1'b0, clock_divisor};
  wire pending = (stepready[moveind] != stepfinished[moveind]);
  wire [WORD_BITS:0]   accum_sum = {1'b0, accum} + {1'b0, work_inc};
  wire [WORD_BITS-1:0] tick_next = tick_cnt + 1'b1;
  // Zero duration still takes one tick
  wire last_tick = active && tick && (tick_next >= move_duration);

  // Free running so back-to-back moves keep the tick grid
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active       <= 1'b0;
      stepfinished <= '0;
      moveind      <= '0;
      step         <= 1'b0;
      dir          <= 1'b0;
      move_done    <= 1'b0;
    end else begin
      step      <= active && tick && accum_sum[WORD_BITS];
      move_done <= last_tick;
      if (!active) begin
        if (pending) begin
          active <= 1'b1;
          dir    <= move_dir;
        end
      end else if (last_tick) begin
        // Hand the slot back and look at the next one
        active                <= 1'b0;
        stepfinished[moveind] <= ~stepfinished[moveind];
        moveind               <= moveind + 1'b1;
      end
    end
  end

  // Idle keeps the next move preloaded, accumulator starts at zero
  always_ff @(posedge CLK) begin
    if (!active) begin
      accum    <= '0;
      work_inc <= increment;
      tick_cnt <= '0;
    end else if (tick) begin
      accum    <= accum_sum[WORD_BITS-1:0];
      // Two's complement add, same bits as unsigned
      work_inc <= work_inc + incrementincrement;
      tick_cnt <= tick_next;
    end
  end

  // A step needs a move still held in the buffer
  a_no_idle_step: assert property (@(posedge CLK) disable iff (!resetn)
    step |-> $past(pending))
    else $error("step pulse without an active move");

endmodule

`default_nettype wire

// File: quad_enc.sv
`timescale 1ns/1ps
`default_nettype none

module quad_enc
  import rapcore_pkg::*;
#(
  parameter int ENC_BITS = 64
) (
  input  wire                        CLK,
  input  wire                        resetn,
  input  wire                        a,
  input  wire                        b,
  output logic signed [ENC_BITS-1:0] count,
  output logic                       faultn
);

  // Two sync flops plus the previous sample
  logic [2:0] a_r;
  logic [2:0] b_r;

  wire a_chg = a_r[2] ^ a_r[1];
  wire b_chg = b_r[2] ^ b_r[1];
  // New A against old B, high when A leads
  wire count_up = a_r[1] ^ b_r[2];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      // Pins expected idle low out of reset
      a_r    <= '0;
      b_r    <= '0;
      count  <= '0;
      faultn <= 1'b1;
    end else begin
      a_r <= {a_r[1:0], a};
      b_r <= {b_r[1:0], b};
      if (a_chg && b_chg) begin
        // Skipped a Gray state, held until reset
        faultn <= 1'b0;
      end else if (a_chg || b_chg) begin
        if (count_up) begin
          count <= count + 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rapcore.sv
`timescale 1ns/1ps
`default_nettype none

module rapcore
  import rapcore_pkg::*;
#(
  parameter int MOVE_BUFFER_BITS = 1,
  parameter int ENC_BITS         = 64
) (
  input  wire CLK,
  input  wire resetn,
  // SPI slave, cs active low
  input  wire sck,
  input  wire cs,
  input  wire copi,
  output wire cipo,
  // Quadrature encoder
  input  wire enc_a,
  input  wire enc_b,
  // Motor drive
  output wire step,
  output wire dir,
  output wire enable,
  // Status
  output wire move_done,
  output wire buffer_dtr,
  output wire enc_faultn
);

  localparam int DEPTH = 1 << MOVE_BUFFER_BITS;

  // SPI word path
  wire                        word_received;
  wire [WORD_BITS-1:0]        word_data_received;
  wire [WORD_BITS-1:0]        word_send_data;

  // Move buffer toward the DDA
  wire [DEPTH-1:0]            stepready;
  wire [DEPTH-1:0]            stepfinished;
  wire [MOVE_BUFFER_BITS-1:0] moveind;
  wire [WORD_BITS-1:0]        move_duration;
  wire [WORD_BITS-1:0]        increment;
  wire [WORD_BITS-1:0]        incrementincrement;
  wire                        move_dir;
  wire [7:0]                  clock_divisor;

  wire signed [ENC_BITS-1:0]  enc_count;

  spi_word spi_word_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .sck                (sck),
    .cs                 (cs),
    .copi               (copi),
    .cipo               (cipo),
    .word_send_data     (word_send_data),
    .word_received      (word_received),
    .word_data_received (word_data_received)
  );

  command_handler #(
    .MOVE_BUFFER_BITS (MOVE_BUFFER_BITS),
    .ENC_BITS         (ENC_BITS)
  ) command_handler_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_received      (word_received),
    .word_data_received (word_data_received),
    .word_send_data     (word_send_data),
    .enc_count          (enc_count),
    .moveind            (moveind),
    .stepfinished       (stepfinished),
    .stepready          (stepready),
    .move_duration      (move_duration),
    .increment          (increment),
    .incrementincrement (incrementincrement),
    .move_dir           (move_dir),
    .clock_divisor      (clock_divisor),
    .enable             (enable),
    .buffer_dtr         (buffer_dtr)
  );

  dda_timer #(
    .MOVE_BUFFER_BITS (MOVE_BUFFER_BITS)
  ) dda_timer_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .clock_divisor      (clock_divisor),
    .move_duration      (move_duration),
    .increment          (increment),
    .incrementincrement (incrementincrement),
    .move_dir           (move_dir),
    .stepready          (stepready),
    .stepfinished       (stepfinished),
    .moveind            (moveind),
    .step               (step),
    .dir                (dir),
    .move_done          (move_done)
  );

  quad_enc #(
    .ENC_BITS (ENC_BITS)
  ) quad_enc_i (
    .CLK    (CLK),
    .resetn (resetn),
    .a      (enc_a),
    .b      (enc_b),
    .count  (enc_count),
    .faultn (enc_faultn)
  );

endmodule

`default_nettype wire

// File: rapcore_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rapcore_checker
  import rapcore_pkg::*;
(
  input wire CLK,
  input wire step,
  input wire dir,
  input wire move_done
);

  // Expected moves, in play order
  int unsigned exp_steps[$];
  logic        exp_dir[$];
  int unsigned exp_gap[$];

  int          outstanding = 0;
  int          errors = 0;
  int          failed_tests = 0;
  int          test_count = 0;
  int          test_errors = 0;
  string       test_name = "";
  // Per-move step count and cycles since the last move_done
  int unsigned step_cnt = 0;
  int unsigned since_done = 0;

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    test_count++;
    if (test_errors == 0) begin
      $display("Test %s passed", test_name);
    end else begin
      failed_tests++;
      $display("Test %s failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic compare(input string name, input logic [WORD_BITS-1:0] expected,
                         input logic [WORD_BITS-1:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic flag(input string what);
    $display("Error in %s: %s", test_name, what);
    errors++;
    test_errors++;
  endtask

  // Reference DDA, carry out of bit 63 is a step, velocity bent after each tick
  task automatic expect_move(input logic [WORD_BITS-1:0] dur, input logic [WORD_BITS-1:0] inc,
                             input logic [WORD_BITS-1:0] incinc, input logic mdir,
                             input int unsigned gap);
    logic [WORD_BITS:0]   sum;
    logic [WORD_BITS-1:0] acc;
    logic [WORD_BITS-1:0] vel;
    int unsigned          ticks;
    int unsigned          steps;
    int unsigned          i;
    acc   = '0;
    vel   = inc;
    steps = 0;
    ticks = int'(dur);
    for (i = 0; i < ticks; i++) begin
      sum = {1'b0, acc} + {1'b0, vel};
      if (sum[WORD_BITS]) begin
        steps++;
      end
      acc = sum[WORD_BITS-1:0];
      vel = vel + incinc;
    end
    exp_steps.push_back(steps);
    exp_dir.push_back(mdir);
    exp_gap.push_back(gap);
    outstanding++;
  endtask

  // Outputs are flops, so mid-cycle values are settled
  always @(negedge CLK) begin
    since_done++;
    if (step) begin
      step_cnt++;
    end
    if (move_done) begin
      if (exp_steps.size() == 0) begin
        flag("move_done pulsed with no move queued");
      end else begin
        compare("steps", exp_steps[0], step_cnt);
        compare("dir", exp_dir[0], dir);
        // Back-to-back only, spacing is duration times divisor
        if (exp_gap[0] != 0) begin
          compare("gap", exp_gap[0], since_done);
        end
        void'(exp_steps.pop_front());
        void'(exp_dir.pop_front());
        void'(exp_gap.pop_front());
        outstanding--;
      end
      step_cnt   = 0;
      since_done = 0;
    end
  end

  task automatic report_totals();
    if (outstanding != 0) begin
      flag("moves were queued but never completed");
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests, errors);
  endtask

endmodule

`default_nettype wire

// File: tb_rapcore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rapcore
  import rapcore_pkg::*;
();

  logic CLK = 1'b0;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  wire  cipo;
  wire  step;
  wire  dir;
  wire  enable;
  wire  move_done;
  wire  buffer_dtr;
  wire  enc_faultn;

  integer      seed = 32'hf7c2_b299;
  // Watchdog limit in cycles, grows with each queued job
  int unsigned budget = 2000;
  int unsigned cycles = 0;
  int unsigned divisor = DEFAULT_CLOCK_DIVISOR;
  // Net encoder steps driven so far
  longint      enc_net = 0;
  logic [63:0] reply;

  always #5 CLK = ~CLK;

  rapcore #(
    .MOVE_BUFFER_BITS (1),
    .ENC_BITS         (64)
  ) dut_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs         (cs),
    .copi       (copi),
    .cipo       (cipo),
    .enc_a      (enc_a),
    .enc_b      (enc_b),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .move_done  (move_done),
    .buffer_dtr (buffer_dtr),
    .enc_faultn (enc_faultn)
  );

  rapcore_checker chk_i (
    .CLK       (CLK),
    .step      (step),
    .dir       (dir),
    .move_done (move_done)
  );

  function automatic int unsigned pick(input int unsigned lo, input int unsigned hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  // Mode 0 host, SCK half period of 4 clocks, MSB first
  task automatic spi_transfer(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    budget += 560;
    @(negedge CLK);
    cs = 1'b0;
    // Let the slave latch its reply
    wait_cycles(8);
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      sck  = 1'b0;
      wait_cycles(4);
      rx[i] = cipo;
      sck   = 1'b1;
      wait_cycles(4);
    end
    sck = 1'b0;
    cs  = 1'b1;
    // Gap so the handler has acted before the next word
    wait_cycles(10);
  endtask

  task automatic set_divisor(input int unsigned d);
    logic [63:0] unused;
    divisor = d;
    spi_transfer({CMD_CLK_DIVISOR, 48'd0, 8'(d)}, unused);
  endtask

  // Random move of four words, snap is the reply to the last word
  task automatic queue_move(input int unsigned lo, input int unsigned hi,
                            input bit gap_check, output logic [63:0] snap);
    logic [63:0] dur;
    logic [63:0] inc;
    logic [63:0] incinc;
    logic        mdir;
    logic [63:0] unused;
    dur    = 64'(pick(lo, hi));
    inc    = rand64() >> pick(0, 6);
    // Small signed velocity change
    incinc = 64'(int'(pick(0, 2000)) - 1000);
    mdir   = (pick(0, 1) == 1);
    budget += int'(dur) * divisor + 100;
    chk_i.expect_move(dur, inc, incinc, mdir, gap_check ? int'(dur) * divisor : 0);
    spi_transfer({CMD_COORDINATED_STEP, 55'd0, mdir}, unused);
    spi_transfer(dur, unused);
    spi_transfer(inc, unused);
    spi_transfer(incinc, snap);
  endtask

  task automatic wait_moves();
    while (chk_i.outstanding != 0) begin
      @(negedge CLK);
    end
    wait_cycles(2);
  endtask

  // Forward toggles A when the pins agree, reverse toggles B
  task automatic enc_move(input int n);
    int k;
    for (k = 0; k < ((n < 0) ? -n : n); k++) begin
      budget += 6;
      if ((enc_a == enc_b) == (n > 0)) begin
        enc_a = ~enc_a;
      end else begin
        enc_b = ~enc_b;
      end
      wait_cycles(4);
    end
    enc_net += n;
  endtask

  initial begin
    int i;
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    wait_cycles(2);
    resetn = 1'b1;
    wait_cycles(4);

    chk_i.start_test("api_version");
    spi_transfer({CMD_API_VERSION, 56'd0}, reply);
    spi_transfer(rand64(), reply);
    chk_i.compare("api_version", {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH},
                  {40'd0, reply[23:0]});
    chk_i.finish_test();

    chk_i.start_test("single_moves");
    for (i = 0; i < 4; i++) begin
      set_divisor(pick(2, 12));
      queue_move(1, 40, 1'b0, reply);
      wait_moves();
    end
    chk_i.finish_test();

    chk_i.start_test("enable_divisor");
    spi_transfer({CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    chk_i.compare("enable_on", 64'd1, {63'd0, enable});
    spi_transfer({CMD_MOTOR_ENABLE, 56'd0}, reply);
    chk_i.compare("enable_off", 64'd0, {63'd0, enable});
    // Long first move keeps the second one waiting behind it
    set_divisor(pick(80, 200));
    queue_move(40, 40, 1'b0, reply);
    queue_move(1, 40, 1'b1, reply);
    wait_moves();
    chk_i.finish_test();

    chk_i.start_test("encoder_snapshot");
    set_divisor(pick(2, 12));
    for (i = 0; i < 3; i++) begin
      enc_move(int'(pick(0, 60)) - 30);
      queue_move(1, 10, 1'b0, reply);
      chk_i.compare("encoder_snapshot", 64'(enc_net), reply);
      wait_moves();
    end
    chk_i.finish_test();

    chk_i.start_test("buffer_flow");
    set_divisor(pick(80, 150));
    queue_move(40, 40, 1'b0, reply);
    queue_move(1, 40, 1'b0, reply);
    // Both slots pending now
    chk_i.compare("buffer_full", 64'd0, {63'd0, buffer_dtr});
    while (chk_i.outstanding == 2) begin
      @(negedge CLK);
    end
    wait_cycles(2);
    chk_i.compare("buffer_free", 64'd1, {63'd0, buffer_dtr});
    queue_move(1, 40, 1'b0, reply);
    wait_moves();
    chk_i.finish_test();

    chk_i.start_test("encoder_fault");
    @(negedge CLK);
    enc_a = ~enc_a;
    enc_b = ~enc_b;
    wait_cycles(6);
    chk_i.compare("fault_low", 64'd0, {63'd0, enc_faultn});
    // Clean steps must not clear it
    enc_move(3);
    wait_cycles(20);
    chk_i.compare("fault_held", 64'd0, {63'd0, enc_faultn});
    enc_a = 1'b0;
    enc_b = 1'b0;
    wait_cycles(6);
    resetn = 1'b0;
    wait_cycles(2);
    resetn = 1'b1;
    wait_cycles(2);
    chk_i.compare("fault_reset", 64'd1, {63'd0, enc_faultn});
    chk_i.finish_test();

    chk_i.report_totals();
    if (chk_i.errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Limit re-read every cycle as the tests add work
  initial begin
    while (cycles < budget) begin
      @(negedge CLK);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rapcore_pkg.sv
spi_word.sv
command_handler.sv
dda_timer.sv
quad_enc.sv
rapcore.sv
rapcore_checker.sv
tb_rapcore.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rapcore
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
